//--- fscpu_pkg.sv
package fscpu_pkg;

	localparam int num_rot_motors = 2;
	localparam int par_word_w = 32;

	typedef logic [31:0] speed_t;
	typedef logic [31:0] step_t;
	typedef logic [31:0] req_cmd_t;
	typedef logic [127:0] req_param_t;
	// one bit per device, see dev_lr and dev_rr
	typedef logic [num_rot_motors-1:0] dev_bmp_t;

	// per-device codes, numbered by device index
	localparam req_cmd_t cmd_motor_lr = 32'd4;
	localparam req_cmd_t cmd_motor_rr = 32'd5;
	localparam req_cmd_t cmd_exe = 32'd30;
	localparam req_cmd_t cmd_stop = 32'd31;

	localparam int dev_lr = 0;
	localparam int dev_rr = 1;

	// command code of each device, by bitmap position
	localparam req_cmd_t motor_cmd [num_rot_motors] = '{cmd_motor_lr, cmd_motor_rr};

	// parameter word fields
	localparam int par_dir_back_bit = 1;
	localparam int par0_lsb = 0;
	localparam int par_speed_lsb = 32;
	localparam int par_step_lsb = 64;

	typedef enum logic [2:0] {
		st_idle,
		st_start,
		st_wait_busy,
		st_busy,
		st_done
	} motor_state_e;

endpackage

//--- fscpu_req_regs.sv
`timescale 1ns/1ps

module fscpu_req_regs (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 req_en,
	input  fscpu_pkg::req_cmd_t   req_cmd,
	input  fscpu_pkg::req_param_t req_param,
	output logic                 dir_back [fscpu_pkg::num_rot_motors],
	output fscpu_pkg::speed_t     speed [fscpu_pkg::num_rot_motors],
	output fscpu_pkg::step_t      step [fscpu_pkg::num_rot_motors]
);
	import fscpu_pkg::*;

	logic [par_word_w-1:0] par0;
	logic [par_word_w-1:0] par1;
	logic [par_word_w-1:0] par2;

	// par3 carries no motor fields
	assign par0 = req_param[par0_lsb +: par_word_w];
	assign par1 = req_param[par_speed_lsb +: par_word_w];
	assign par2 = req_param[par_step_lsb +: par_word_w];

	for (genvar i = 0; i < num_rot_motors; i++) begin : g_motor
		logic hit;

		assign hit = req_en && (req_cmd == motor_cmd[i]);

		always_ff @(posedge clk) begin
			if (!resetn) begin
				dir_back[i] <= 1'b0;
				speed[i] <= '0;
				step[i] <= '0;
			end else if (hit) begin
				dir_back[i] <= par0[par_dir_back_bit];
				speed[i] <= par1;
				step[i] <= par2;
			end
		end
	end

endmodule

//--- fscpu_exe_ctl.sv
`timescale 1ns/1ps

module fscpu_exe_ctl (
	input  logic                clk,
	input  logic                resetn,
	input  logic                req_en,
	input  fscpu_pkg::req_cmd_t  req_cmd,
	input  fscpu_pkg::dev_bmp_t  done,
	output fscpu_pkg::dev_bmp_t  run,
	output logic                req_done
);
	import fscpu_pkg::*;

	dev_bmp_t stage_bmp;
	dev_bmp_t oper_bmp;
	dev_bmp_t motor_hit;
	logic all_done;

	// one-hot of the device addressed by the command
	always_comb begin
		motor_hit = '0;
		for (int i = 0; i < num_rot_motors; i++) begin
			if (req_cmd == motor_cmd[i])
				motor_hit[i] = 1'b1;
		end
	end

	assign all_done = ((done & oper_bmp) == oper_bmp) && (oper_bmp != '0);

	// staged devices wait here for the next EXE
	always_ff @(posedge clk) begin
		if (!resetn) begin
			stage_bmp <= '0;
		end else if (req_en) begin
			if (motor_hit != '0)
				stage_bmp <= stage_bmp | motor_hit;
			else if (req_cmd != cmd_exe)
				stage_bmp <= '0;
		end else if (all_done) begin
			stage_bmp <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			oper_bmp <= '0;
		end else if (req_en) begin
			if (req_cmd == cmd_exe)
				oper_bmp <= stage_bmp;
			else if (req_cmd == cmd_stop)
				oper_bmp <= '0;
		end else if (all_done) begin
			oper_bmp <= '0;
		end
	end

	// sticky until the host sends anything
	always_ff @(posedge clk) begin
		if (!resetn)
			req_done <= 1'b0;
		else if (req_en)
			req_done <= 1'b0;
		else if (all_done)
			req_done <= 1'b1;
	end

	assign run = oper_bmp;

endmodule

//--- rotate_motor_ctl.sv
`timescale 1ns/1ps

module rotate_motor_ctl (
	input  logic              clk,
	input  logic              resetn,
	input  logic              run,
	input  logic              dir_back,
	input  fscpu_pkg::speed_t  req_speed,
	input  fscpu_pkg::step_t   req_step,
	output logic              done,
	output logic              m_sel,
	input  logic              m_state,
	output logic              m_start,
	output logic              m_stop,
	output fscpu_pkg::speed_t  m_speed,
	output fscpu_pkg::step_t   m_step,
	output logic              m_dir
);
	import fscpu_pkg::*;

	motor_state_e state;
	logic moving;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= st_idle;
		end else if (!run) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					state <= st_start;
				end
				st_start: begin
					state <= st_wait_busy;
				end
				// motor takes a cycle or more to report busy
				st_wait_busy: begin
					if (m_state)
						state <= st_busy;
				end
				st_busy: begin
					if (!m_state)
						state <= st_done;
				end
				st_done: begin
					state <= st_done;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// latch the request on the way into start
	always_ff @(posedge clk) begin
		if (state == st_idle && run) begin
			m_speed <= req_speed;
			m_step <= req_step;
			m_dir <= dir_back;
		end
	end

	assign moving = (state == st_wait_busy) || (state == st_busy);

	assign m_sel = (state != st_idle);
	assign m_start = (state == st_start);
	// abort only while the motor may be turning
	assign m_stop = moving && !run;
	assign done = (state == st_done);

endmodule

//--- fscpu.sv
`timescale 1ns/1ps

module fscpu (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 req_en,
	input  fscpu_pkg::req_cmd_t   req_cmd,
	input  fscpu_pkg::req_param_t req_param,
	output logic                 req_done,

	output logic                 mlr_sel,
	input  logic                 mlr_state,
	output logic                 mlr_start,
	output logic                 mlr_stop,
	output fscpu_pkg::speed_t     mlr_speed,
	output fscpu_pkg::step_t      mlr_step,
	output logic                 mlr_dir,

	output logic                 mrr_sel,
	input  logic                 mrr_state,
	output logic                 mrr_start,
	output logic                 mrr_stop,
	output fscpu_pkg::speed_t     mrr_speed,
	output fscpu_pkg::step_t      mrr_step,
	output logic                 mrr_dir
);
	import fscpu_pkg::*;

	logic dir_back [num_rot_motors];
	speed_t speed [num_rot_motors];
	step_t step [num_rot_motors];
	dev_bmp_t run;
	dev_bmp_t done;

	fscpu_req_regs req_regs (
		.clk      (clk),
		.resetn   (resetn),
		.req_en   (req_en),
		.req_cmd  (req_cmd),
		.req_param(req_param),
		.dir_back (dir_back),
		.speed    (speed),
		.step     (step)
	);

	fscpu_exe_ctl exe_ctl (
		.clk     (clk),
		.resetn  (resetn),
		.req_en  (req_en),
		.req_cmd (req_cmd),
		.done    (done),
		.run     (run),
		.req_done(req_done)
	);

	// left rotate motor
	rotate_motor_ctl lr_motor_ctl (
		.clk      (clk),
		.resetn   (resetn),
		.run      (run[dev_lr]),
		.dir_back (dir_back[dev_lr]),
		.req_speed(speed[dev_lr]),
		.req_step (step[dev_lr]),
		.done     (done[dev_lr]),
		.m_sel    (mlr_sel),
		.m_state  (mlr_state),
		.m_start  (mlr_start),
		.m_stop   (mlr_stop),
		.m_speed  (mlr_speed),
		.m_step   (mlr_step),
		.m_dir    (mlr_dir)
	);

	// right rotate motor
	rotate_motor_ctl rr_motor_ctl (
		.clk      (clk),
		.resetn   (resetn),
		.run      (run[dev_rr]),
		.dir_back (dir_back[dev_rr]),
		.req_speed(speed[dev_rr]),
		.req_step (step[dev_rr]),
		.done     (done[dev_rr]),
		.m_sel    (mrr_sel),
		.m_state  (mrr_state),
		.m_start  (mrr_start),
		.m_stop   (mrr_stop),
		.m_speed  (mrr_speed),
		.m_step   (mrr_step),
		.m_dir    (mrr_dir)
	);

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

endmodule

//--- tb_motor_model.sv
`timescale 1ns/1ps

module tb_motor_model (
	input  logic              clk,
	input  logic              resetn,
	input  logic              sel,
	input  logic              start,
	input  logic              stop,
	input  fscpu_pkg::step_t   step,
	output logic              state
);
	import fscpu_pkg::*;

	step_t remaining;

	always @(posedge clk) begin
		if (!resetn) begin
			state <= 1'b0;
			remaining <= '0;
		end else if (stop) begin
			state <= 1'b0;
			remaining <= '0;
		end else if (sel && start) begin
			state <= 1'b1;
			remaining <= step;
		end else if (state) begin
			// busy for step cycles, at least one
			if (remaining <= 32'd1)
				state <= 1'b0;
			else
				remaining <= remaining - 32'd1;
		end
	end

endmodule

//--- fscpu_assert.sv
`timescale 1ns/1ps

module fscpu_assert (
	input logic clk,
	input logic resetn,
	input logic m_sel,
	input logic m_start,
	input logic m_stop,
	input logic done
);

	start_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		m_start |=> !m_start)
		else $error("m_start held for more than one cycle");

	start_with_sel: assert property (@(posedge clk) disable iff (!resetn)
		m_start |-> m_sel)
		else $error("m_start raised while m_sel is low");

	start_stop_apart: assert property (@(posedge clk) disable iff (!resetn)
		!(m_start && m_stop))
		else $error("m_start and m_stop high together");

	// a finished channel never restarts on its own
	done_no_start: assert property (@(posedge clk) disable iff (!resetn)
		done |-> !m_start)
		else $error("m_start raised while done is high");

endmodule

bind rotate_motor_ctl fscpu_assert motor_assert (
	.clk    (clk),
	.resetn (resetn),
	.m_sel  (m_sel),
	.m_start(m_start),
	.m_stop (m_stop),
	.done   (done)
);

//--- tb_fscpu.sv
`timescale 1ns/1ps

module tb_fscpu;
	import fscpu_pkg::*;

	localparam req_cmd_t cmd_unknown = 32'd7;
	localparam int max_step = 40;
	localparam int long_bound = max_step + 20;

	logic clk;
	logic resetn;
	logic req_en;
	req_cmd_t req_cmd;
	req_param_t req_param;
	logic req_done;
	logic ch_sel [2];
	logic ch_state [2];
	logic ch_start [2];
	logic ch_stop [2];
	speed_t ch_speed [2];
	step_t ch_step [2];
	logic ch_dir [2];
	string ch_name [2] = '{"mlr_", "mrr_"};

	// stimulus table, one entry per request
	req_cmd_t row_cmd [$];
	logic row_dir [$];
	step_t row_step [$];
	speed_t row_speed [$];
	dev_bmp_t row_start [$];
	dev_bmp_t row_stop [$];
	logic row_done [$];
	int row_bound [$];

	speed_t exp_speed [2];
	step_t exp_step [2];
	logic exp_dir [2];
	int start_cnt [2];
	int stop_cnt [2];
	logic done_seen;
	int value_errors = 0;
	int event_errors = 0;
	int cycle_limit = 0;
	logic [31:0] lfsr_state = 32'h2e04_f7f0;

	tb_clk_gen clk_gen (.clk(clk));

	fscpu fscpu_inst (
		.clk      (clk),
		.resetn   (resetn),
		.req_en   (req_en),
		.req_cmd  (req_cmd),
		.req_param(req_param),
		.req_done (req_done),
		.mlr_sel  (ch_sel[0]),
		.mlr_state(ch_state[0]),
		.mlr_start(ch_start[0]),
		.mlr_stop (ch_stop[0]),
		.mlr_speed(ch_speed[0]),
		.mlr_step (ch_step[0]),
		.mlr_dir  (ch_dir[0]),
		.mrr_sel  (ch_sel[1]),
		.mrr_state(ch_state[1]),
		.mrr_start(ch_start[1]),
		.mrr_stop (ch_stop[1]),
		.mrr_speed(ch_speed[1]),
		.mrr_step (ch_step[1]),
		.mrr_dir  (ch_dir[1])
	);

	for (genvar c = 0; c < 2; c++) begin : g_model
		tb_motor_model motor (
			.clk   (clk),
			.resetn(resetn),
			.sel   (ch_sel[c]),
			.start (ch_start[c]),
			.stop  (ch_stop[c]),
			.step  (ch_step[c]),
			.state (ch_state[c])
		);
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic random_word(output logic [31:0] value);
		value = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_eq(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Fail %0t %s expected %h got %h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_event(input bit ok, input string what);
		assert (ok) else begin
			$display("at %0t: %s", $time, what);
			event_errors++;
		end
	endtask

	task automatic add_row(input req_cmd_t cmd, input logic dir, input step_t step,
			input dev_bmp_t start_mask, input dev_bmp_t stop_mask, input logic exp_done,
			input int bound);
		speed_t speed;
		random_word(speed);
		row_cmd.push_back(cmd);
		row_dir.push_back(dir);
		row_step.push_back(step);
		row_speed.push_back(speed);
		row_start.push_back(start_mask);
		row_stop.push_back(stop_mask);
		row_done.push_back(exp_done);
		row_bound.push_back(bound);
	endtask

	task automatic sample_cycle(input int r);
		@(negedge clk);
		req_en = 1'b0;
		for (int c = 0; c < 2; c++) begin
			if (ch_start[c]) begin
				start_cnt[c]++;
				check_eq({ch_name[c], "speed"}, exp_speed[c], ch_speed[c]);
				check_eq({ch_name[c], "step"}, exp_step[c], ch_step[c]);
				check_eq({ch_name[c], "dir"}, 32'(exp_dir[c]), 32'(ch_dir[c]));
			end
			if (ch_stop[c])
				stop_cnt[c]++;
			// unstaged channels stay deselected
			if (row_cmd[r] == cmd_exe && !row_start[r][c])
				check_eq({ch_name[c], "sel"}, 32'd0, 32'(ch_sel[c]));
		end
		if (req_done && !done_seen) begin
			done_seen = 1'b1;
			for (int c = 0; c < 2; c++)
				check_eq({ch_name[c], "state"}, 32'd0, 32'(ch_state[c]));
		end
	endtask

	task automatic apply_row(input int r);
		int ch;
		ch = -1;
		if (row_cmd[r] == cmd_motor_lr)
			ch = 0;
		else if (row_cmd[r] == cmd_motor_rr)
			ch = 1;
		if (ch >= 0) begin
			exp_speed[ch] = row_speed[r];
			exp_step[ch] = row_step[r];
			exp_dir[ch] = row_dir[r];
		end
		req_en = 1'b1;
		req_cmd = row_cmd[r];
		// par3 unused, par2 step, par1 speed, par0 bit 1 backward
		req_param = {32'h0, row_step[r], row_speed[r], 30'h0, row_dir[r], 1'b0};
		for (int c = 0; c < 2; c++) begin
			start_cnt[c] = 0;
			stop_cnt[c] = 0;
		end
		done_seen = 1'b0;
		for (int n = 0; n < row_bound[r]; n++) begin
			sample_cycle(r);
			if (row_done[r] && done_seen)
				break;
			if (row_stop[r] != '0 && stop_cnt[0] + stop_cnt[1] > 0)
				break;
		end
		repeat (3) sample_cycle(r);
		for (int c = 0; c < 2; c++) begin
			check_event(start_cnt[c] == int'(row_start[r][c]),
				$sformatf("row %0d: %sstart pulsed %0d times instead of %0d",
				r, ch_name[c], start_cnt[c], int'(row_start[r][c])));
			check_event(stop_cnt[c] == int'(row_stop[r][c]),
				$sformatf("row %0d: %sstop pulsed %0d times instead of %0d",
				r, ch_name[c], stop_cnt[c], int'(row_stop[r][c])));
			if (row_done[r] || row_stop[r] != '0)
				check_eq({ch_name[c], "sel"}, 32'd0, 32'(ch_sel[c]));
		end
		check_event(done_seen == row_done[r], $sformatf("row %0d: req_done %s", r,
			row_done[r] ? "did not rise in time" : "rose without a finished run"));
		if (row_done[r])
			check_eq("req_done", 32'd1, 32'(req_done));
	endtask

	initial begin : watchdog
		int cycles;
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		resetn = 1'b0;
		req_en = 1'b0;
		req_cmd = '0;
		req_param = '0;
		done_seen = 1'b0;
		for (int c = 0; c < 2; c++) begin
			exp_speed[c] = '0;
			exp_step[c] = '0;
			exp_dir[c] = 1'b0;
		end

		add_row(cmd_motor_lr, 1'b1, 5, 2'b00, 2'b00, 1'b0, 2);
		add_row(cmd_exe, 1'b0, 0, 2'b01, 2'b00, 1'b1, long_bound);
		add_row(cmd_motor_rr, 1'b0, 3, 2'b00, 2'b00, 1'b0, 2);
		add_row(cmd_motor_lr, 1'b0, 9, 2'b00, 2'b00, 1'b0, 2);
		add_row(cmd_exe, 1'b0, 0, 2'b11, 2'b00, 1'b1, long_bound);
		// staging was cleared by the completed run
		add_row(cmd_exe, 1'b0, 0, 2'b00, 2'b00, 1'b0, 8);
		add_row(cmd_motor_lr, 1'b1, max_step, 2'b00, 2'b00, 1'b0, 2);
		add_row(cmd_motor_rr, 1'b1, max_step, 2'b00, 2'b00, 1'b0, 2);
		add_row(cmd_exe, 1'b0, 0, 2'b11, 2'b00, 1'b0, 6);
		add_row(cmd_stop, 1'b0, 0, 2'b00, 2'b11, 1'b0, 6);
		add_row(cmd_motor_rr, 1'b0, 4, 2'b00, 2'b00, 1'b0, 2);
		add_row(cmd_unknown, 1'b0, 0, 2'b00, 2'b00, 1'b0, 2);
		add_row(cmd_exe, 1'b0, 0, 2'b00, 2'b00, 1'b0, 8);
		add_row(cmd_motor_rr, 1'b1, 6, 2'b00, 2'b00, 1'b0, 2);
		add_row(cmd_motor_rr, 1'b0, 2, 2'b00, 2'b00, 1'b0, 2);
		add_row(cmd_exe, 1'b0, 0, 2'b10, 2'b00, 1'b1, long_bound);
		cycle_limit = row_cmd.size() * long_bound + 8 + 10;

		repeat (8) @(negedge clk);
		resetn = 1'b1;
		// quiet outputs with no requests
		repeat (10) begin
			@(negedge clk);
			check_eq("req_done", 32'd0, 32'(req_done));
			for (int c = 0; c < 2; c++) begin
				check_eq({ch_name[c], "sel"}, 32'd0, 32'(ch_sel[c]));
				check_eq({ch_name[c], "start"}, 32'd0, 32'(ch_start[c]));
				check_eq({ch_name[c], "stop"}, 32'd0, 32'(ch_stop[c]));
			end
		end

		for (int r = 0; r < row_cmd.size(); r++)
			apply_row(r);

		$display("summary: %0d value errors, %0d other errors", value_errors, event_errors);
		if (value_errors + event_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- fscpu.f
fscpu_pkg.sv
fscpu_req_regs.sv
fscpu_exe_ctl.sv
rotate_motor_ctl.sv
fscpu.sv
tb_clk_gen.sv
tb_motor_model.sv
fscpu_assert.sv
tb_fscpu.sv

//--- Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_fscpu
FILELIST ?= fscpu.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
